//--- Bender.yml
package:
  name: arcade_io

sources:
  - source/arcade_pkg.sv
  - source/game_select.sv
  - source/stick_quantizer.sv
  - source/control_mapper.sv
  - source/blank_timer.sv
  - source/audio_mixer.sv
  - source/arcade_io_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_arcade_io.sv

//--- bench/clock_gen.sv
/*
 * Testbench clock and reset
 * 20 ns system clock, reset held for the first 8 cycles
 */
`timescale 1ns/1ns

module clock_gen
(
	output logic clk_sys,
	output logic reset
);

	initial
	begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

//--- bench/tb_arcade_io.sv
/*
 * Arcade I/O testbench
 * Drives the download port, pads, syncs and audio of the top level
 * and checks every output against the board rules
 */
`timescale 1ns/1ns

module tb_arcade_io;
	import arcade_pkg::*;

	localparam int LINE_CYCLES  = 700;
	localparam int FRAME_LINES  = 270;
	localparam int VIDEO_LINES  = 286;
	localparam int HS_WIDTH     = 48;
	localparam int AUDIO_SETTLE = 10000;
	// About 286 lines of 700 cycles plus two audio settles, with margin
	localparam int CYCLE_LIMIT  = 400000;
	localparam int HB_RISE      = 2 + 2 * HBLANK_START + 1;
	localparam int HB_FALL      = 2 + 2 * HBLANK_END + 1;

	logic          clk_sys;
	logic          reset;
	logic          dl_wr;
	dl_index_t     dl_index;
	dl_addr_t      dl_addr;
	io_byte_t      dl_data;
	joy_word_t     joy1;
	joy_word_t     joy2;
	stick_word_t   stick1;
	stick_word_t   stick2;
	logic [1:0]    control_mode;
	logic          hs;
	logic          vs;
	io_byte_t      main_audio;
	audio_sample_t speech;
	io_byte_t      ja;
	io_byte_t      jb;
	io_byte_t      sw;
	logic [2:0]    btn;
	logic          sin_fire;
	logic          sin_bomb;
	logic          sinistar;
	logic          landscape;
	logic          hblank;
	logic          vblank;
	logic          ce_pix;
	audio_sample_t audio_out;

	// Reference state kept from the bench's own stimulus
	game_id_t exp_game;
	io_byte_t exp_dip0;
	logic     p2_active;
	int       mismatch_count = 0;
	int       other_count    = 0;
	int       cycle_count    = 0;

	int       axis_edges [12] = '{32, -32, 33, -33, 64, -64, 65, -65, 96, -96, 97, -97};
	game_id_t digital_games [4] = '{GAME_JOUST, GAME_BUBBLES, GAME_PLAYBALL, 8'd2};

	clock_gen u_clock
	(
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	arcade_io_top DUT
	(
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.joy1         (joy1),
		.joy2         (joy2),
		.stick1       (stick1),
		.stick2       (stick2),
		.control_mode (control_mode),
		.hs           (hs),
		.vs           (vs),
		.main_audio   (main_audio),
		.speech       (speech),
		.ja           (ja),
		.jb           (jb),
		.sw           (sw),
		.btn          (btn),
		.sin_fire     (sin_fire),
		.sin_bomb     (sin_bomb),
		.sinistar     (sinistar),
		.landscape    (landscape),
		.hblank       (hblank),
		.vblank       (vblank),
		.ce_pix       (ce_pix),
		.audio_out    (audio_out)
	);

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string test, input string sig,
	                               input logic [31:0] expected, input logic [31:0] actual);
		mismatch_count++;
		$display("mismatch %s %s expected %0h actual %0h", test, sig, expected, actual);
	endtask

	task automatic report_failure(input string what);
		other_count++;
		$display("Error: %s", what);
	endtask

	task automatic close_run();
		$display("Summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Board rules
	//////////////////////////////////////////////////

	function automatic logic [15:0] random_word();
		int r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic logic [3:0] dir_nibble(input joy_word_t j);
		return {j[JOY_RIGHT], j[JOY_LEFT], j[JOY_DOWN], j[JOY_UP]};
	endfunction

	// Distance from center picks the band and the side picks the code
	function automatic stick_pos_t axis_pos(input stick_axis_t v, input logic y_axis);
		int         iv;
		int         mag;
		int         band;
		stick_pos_t p;
		iv   = v;
		mag  = (iv < 0) ? -iv : iv;
		band = (mag > 96) ? 3 : (mag > 64) ? 2 : (mag > 32) ? 1 : 0;
		if ((iv < 0) ^ y_axis)
			p = (band == 3) ? 4'd0 : (band == 2) ? 4'd4 : (band == 1) ? 4'd6 : 4'd7;
		else
			p = (band == 3) ? 4'd8 : (band == 2) ? 4'd9 : (band == 1) ? 4'd11 : 4'd7;
		return p;
	endfunction

	function automatic stick_pos_t pad_pos(input logic minus, input logic plus);
		return minus ? 4'd0 : (plus ? 4'd8 : 4'd7);
	endfunction

	function automatic int boosted_speech(input audio_sample_t s);
		int centered;
		centered = (int'(s) - 32768) * 4;
		if (centered > 32767)
			centered = 32767;
		if (centered < -32768)
			centered = -32768;
		return centered + 32768;
	endfunction

	task automatic predict_board(output io_byte_t e_ja, output io_byte_t e_jb,
	                             output io_byte_t e_sw, output logic [2:0] e_btn,
	                             output logic e_fire, output logic e_bomb,
	                             output logic e_sin, output logic e_land);
		joy_word_t   m;
		stick_word_t s;
		logic [3:0]  lo;
		logic [3:0]  hi;
		stick_pos_t  px;
		stick_pos_t  py;
		m  = joy1 | joy2;
		s  = p2_active ? stick2 : stick1;
		px = axis_pos(s[7:0], 1'b0);
		py = axis_pos(s[15:8], 1'b1);
		if (px == STICK_CENTER)
			px = pad_pos(m[JOY_LEFT], m[JOY_RIGHT]);
		if (py == STICK_CENTER)
			py = pad_pos(m[JOY_DOWN], m[JOY_UP]);
		e_sw   = exp_dip0 | {6'b000000, m[JOY_ADVANCE], m[JOY_AUTOUP]};
		e_fire = ~m[JOY_FIRE_A];
		e_bomb = ~m[JOY_FIRE_B];
		e_sin  = (exp_game == GAME_SINISTAR);
		e_land = !(exp_game == GAME_SINISTAR || exp_game == GAME_PLAYBALL);
		e_ja   = 8'hff;
		e_btn  = 3'b000;
		case (exp_game)
			GAME_ROBOTRON:
			begin
				lo = control_mode[1] ? dir_nibble(joy1) : dir_nibble(m);
				if (control_mode[1])
					hi = dir_nibble(joy2);
				else if (control_mode[0])
					hi = dir_nibble(m);
				else
					hi = {m[JOY_FIRE_A], m[JOY_FIRE_D], m[JOY_FIRE_B], m[JOY_FIRE_C]};
				e_btn = {m[JOY_START1], m[JOY_START2], m[JOY_COIN]};
				e_ja  = ~{hi, lo};
			end
			GAME_JOUST:
			begin
				e_btn = {m[JOY_START2], m[JOY_START1], m[JOY_COIN]};
				e_ja  = ~{5'b00000, joy1[JOY_FIRE_A], joy1[JOY_RIGHT], joy1[JOY_LEFT]};
			end
			GAME_BUBBLES:
			begin
				e_btn = {m[JOY_START2], m[JOY_START1], m[JOY_COIN]};
				e_ja  = ~{4'b0000, dir_nibble(m)};
			end
			GAME_SINISTAR:
			begin
				e_btn = {m[JOY_START1], m[JOY_START2], m[JOY_COIN]};
				e_ja  = ~{px, py};
			end
			GAME_PLAYBALL:
			begin
				e_btn = {2'b00, m[JOY_COIN]};
				e_ja  = ~{4'b0000, m[JOY_START2], m[JOY_RIGHT], m[JOY_LEFT], m[JOY_START1]};
			end
			default:
				e_ja = 8'hff;
		endcase
		// Joust is the only board with a separate player 2 byte
		if (exp_game == GAME_JOUST)
			e_jb = ~{5'b00000, joy2[JOY_FIRE_A], joy2[JOY_RIGHT], joy2[JOY_LEFT]};
		else
			e_jb = e_ja;
	endtask

	//////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////

	task automatic check_board(input string test);
		io_byte_t   e_ja;
		io_byte_t   e_jb;
		io_byte_t   e_sw;
		logic [2:0] e_btn;
		logic       e_fire;
		logic       e_bomb;
		logic       e_sin;
		logic       e_land;
		predict_board(e_ja, e_jb, e_sw, e_btn, e_fire, e_bomb, e_sin, e_land);
		assert (ja === e_ja) else report_mismatch(test, "ja", e_ja, ja);
		assert (jb === e_jb) else report_mismatch(test, "jb", e_jb, jb);
		assert (sw === e_sw) else report_mismatch(test, "sw", e_sw, sw);
		assert (btn === e_btn) else report_mismatch(test, "btn", e_btn, btn);
		assert (sin_fire === e_fire) else report_mismatch(test, "sin_fire", e_fire, sin_fire);
		assert (sin_bomb === e_bomb) else report_mismatch(test, "sin_bomb", e_bomb, sin_bomb);
		assert (sinistar === e_sin) else report_mismatch(test, "sinistar", e_sin, sinistar);
		assert (landscape === e_land) else report_mismatch(test, "landscape", e_land, landscape);
	endtask

	// Held for two edges so the player select flop has seen the pads
	task automatic apply_pads(input string test, input joy_word_t pad1, input joy_word_t pad2,
	                          input stick_word_t s1, input stick_word_t s2);
		@(posedge clk_sys);
		joy1   <= pad1;
		joy2   <= pad2;
		stick1 <= s1;
		stick2 <= s2;
		@(posedge clk_sys);
		if (pad1 != '0)
			p2_active = 1'b0;
		else if (pad2 != '0)
			p2_active = 1'b1;
		@(negedge clk_sys);
		check_board(test);
	endtask

	task automatic map_random(input string test, input int count);
		for (int n = 0; n < count; n++)
			apply_pads(test, random_word(), random_word(), random_word(), random_word());
	endtask

	task automatic download(input string test, input dl_index_t idx, input dl_addr_t addr,
	                        input io_byte_t data);
		@(posedge clk_sys);
		dl_wr    <= 1'b1;
		dl_index <= idx;
		dl_addr  <= addr;
		dl_data  <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		if (idx == GAME_INDEX)
			exp_game = data;
		else if (idx == DIP_INDEX && addr == '0)
			exp_dip0 = data;
		@(negedge clk_sys);
		check_board(test);
	endtask

	task automatic check_audio(input string test, input io_byte_t main_val,
	                           input audio_sample_t speech_val);
		int mix;
		int expected;
		int actual;
		@(posedge clk_sys);
		main_audio <= main_val;
		speech     <= speech_val;
		repeat (AUDIO_SETTLE) @(posedge clk_sys);
		@(negedge clk_sys);
		mix = int'(main_val) * 256;
		if (exp_game == GAME_SINISTAR)
			mix = mix + boosted_speech(speech_val);
		else
			mix = mix + int'(speech_val);
		expected = mix / 8;
		actual   = audio_out;
		assert (actual >= expected - 1 && actual <= expected + 1)
		else
			report_mismatch(test, "audio_out", expected, actual);
	endtask

	task automatic run_video();
		int   line;
		int   k;
		logic exp_vb;
		logic exp_hb;
		logic prev_ce;
		exp_vb  = 1'b0;
		prev_ce = 1'b0;
		for (line = 0; line < VIDEO_LINES; line++)
		begin
			for (k = 0; k < LINE_CYCLES; k++)
			begin
				@(posedge clk_sys);
				hs <= (k < HS_WIDTH);
				vs <= ((line % FRAME_LINES) < 3);
				@(negedge clk_sys);
				// Line count settles on edge 2 of each line and vblank one edge later
				if (k == 3 && (line % FRAME_LINES) == VBLANK_START)
					exp_vb = 1'b1;
				if (k == 3 && (line % FRAME_LINES) == VBLANK_END)
					exp_vb = 1'b0;
				assert (vblank === exp_vb)
				else
					report_mismatch("video", "vblank", exp_vb, vblank);
				if (line > 0)
				begin
					exp_hb = !(k >= HB_FALL && k < HB_RISE);
					assert (hblank === exp_hb)
					else
						report_mismatch("video", "hblank", exp_hb, hblank);
					assert (ce_pix !== prev_ce)
					else
						report_mismatch("video", "ce_pix", ~prev_ce, ce_pix);
				end
				prev_ce = ce_pix;
			end
		end
	endtask

	always @(posedge clk_sys)
		cycle_count <= cycle_count + 1;

	initial
	begin
		wait (cycle_count >= CYCLE_LIMIT);
		report_failure("timeout, the run did not end within the cycle limit");
		close_run();
	end

	initial
	begin
		logic [2:0]  mode;
		stick_axis_t ax;
		stick_axis_t ay;
		int          seed_discard;
		dl_wr        = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		joy1         = '0;
		joy2         = '0;
		stick1       = '0;
		stick2       = '0;
		control_mode = 2'b00;
		hs           = 1'b0;
		vs           = 1'b0;
		main_audio   = '0;
		speech       = '0;
		exp_game     = GAME_ROBOTRON;
		exp_dip0     = '0;
		p2_active    = 1'b0;
		seed_discard = $urandom(32'h3a40_81ac);

		@(posedge clk_sys);
		while (reset)
			@(posedge clk_sys);
		@(negedge clk_sys);
		assert (!$isunknown({ja, jb, sw, btn, sin_fire, sin_bomb, sinistar, landscape,
		                     hblank, vblank, ce_pix, audio_out}))
		else
			report_failure("outputs hold unknown bits after reset");
		assert (audio_out === 16'h0000)
		else
			report_mismatch("audio_reset", "audio_out", 0, audio_out);

		// Game select and DIP download
		apply_pads("default_game", 16'h0401, 16'h0000, 16'h0000, 16'h0000);
		download("game_joust", GAME_INDEX, 25'h0000123, GAME_JOUST);
		download("dip_write", DIP_INDEX, '0, 8'ha5);
		download("dip_other_addr", DIP_INDEX, 25'd3, 8'h3c);
		download("other_index", 8'd5, '0, GAME_PLAYBALL);
		download("game_robotron", GAME_INDEX, '0, GAME_ROBOTRON);

		// Digital boards
		for (mode = 0; mode < 4; mode++)
		begin
			@(posedge clk_sys);
			control_mode <= mode[1:0];
			map_random("robotron_map", 24);
		end
		for (int g = 0; g < 4; g++)
		begin
			download("game_load", GAME_INDEX, '0, digital_games[g]);
			map_random("digital_map", 24);
		end
		check_audio("audio_plain", 8'h5a, 16'h1234);

		// Sinistar stick
		download("game_sinistar", GAME_INDEX, '0, GAME_SINISTAR);
		for (int i = 0; i < 12; i++)
		begin
			ax = axis_edges[i];
			ay = -axis_edges[i];
			apply_pads("stick_edge", 16'h0000, 16'h0000, {ay, ax}, {ax, ay});
		end
		apply_pads("stick_p1", 16'h0010, 16'h0000, 16'h9c64, 16'h32ce);
		apply_pads("stick_p2", 16'h0000, 16'h0020, 16'h9c64, 16'h32ce);
		apply_pads("stick_hold", 16'h0000, 16'h0000, 16'h9c64, 16'h32ce);
		apply_pads("stick_p1_first", 16'h0010, 16'h0020, 16'h9c64, 16'h32ce);
		for (int i = 0; i < 16; i++)
		begin
			ax = ($urandom % 65) - 32;
			ay = ($urandom % 65) - 32;
			apply_pads("stick_center", random_word() & 16'h000f, random_word() & 16'h000f,
			           {ay, ax}, {ax, ay});
		end
		for (int i = 0; i < 32; i++)
			apply_pads("stick_random", (($urandom % 3) == 0) ? 16'h0000 : random_word(),
			           random_word(), random_word(), random_word());
		check_audio("audio_boost", 8'h40, 16'hf000);

		run_video();
		close_run();
	end

endmodule

//--- flist.f
source/arcade_pkg.sv
source/game_select.sv
source/stick_quantizer.sv
source/control_mapper.sv
source/blank_timer.sv
source/audio_mixer.sv
source/arcade_io_top.sv
bench/clock_gen.sv
bench/tb_arcade_io.sv

//--- source/arcade_io_top.sv
/*
 * Arcade I/O top
 * Control, blanking and audio glue around the Williams SoC
 */
`timescale 1ns/1ns

module arcade_io_top
#(
	parameter int LPF_SHIFT    = arcade_pkg::LPF_SHIFT,
	parameter int HBLANK_START = arcade_pkg::HBLANK_START,
	parameter int HBLANK_END   = arcade_pkg::HBLANK_END,
	parameter int VBLANK_START = arcade_pkg::VBLANK_START,
	parameter int VBLANK_END   = arcade_pkg::VBLANK_END
)
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_wr,
	input  arcade_pkg::dl_index_t     dl_index,
	input  arcade_pkg::dl_addr_t      dl_addr,
	input  arcade_pkg::io_byte_t      dl_data,
	input  arcade_pkg::joy_word_t     joy1,
	input  arcade_pkg::joy_word_t     joy2,
	input  arcade_pkg::stick_word_t   stick1,
	input  arcade_pkg::stick_word_t   stick2,
	input  logic [1:0]                control_mode,
	input  logic                      hs,
	input  logic                      vs,
	input  arcade_pkg::io_byte_t      main_audio,
	input  arcade_pkg::audio_sample_t speech,
	output arcade_pkg::io_byte_t      ja,
	output arcade_pkg::io_byte_t      jb,
	output arcade_pkg::io_byte_t      sw,
	output logic [2:0]                btn,
	output logic                      sin_fire,
	output logic                      sin_bomb,
	output logic                      sinistar,
	output logic                      landscape,
	output logic                      hblank,
	output logic                      vblank,
	output logic                      ce_pix,
	output arcade_pkg::audio_sample_t audio_out
);
	import arcade_pkg::*;

	game_id_t game;
	io_byte_t dip0;

	game_select u_game_select
	(
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip0     (dip0)
	);

	control_mapper u_control_mapper
	(
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game         (game),
		.dip0         (dip0),
		.control_mode (control_mode),
		.joy1         (joy1),
		.joy2         (joy2),
		.stick1       (stick1),
		.stick2       (stick2),
		.ja           (ja),
		.jb           (jb),
		.sw           (sw),
		.btn          (btn),
		.sin_fire     (sin_fire),
		.sin_bomb     (sin_bomb),
		.sinistar     (sinistar),
		.landscape    (landscape)
	);

	blank_timer
	#(
		.HBLANK_START (HBLANK_START),
		.HBLANK_END   (HBLANK_END),
		.VBLANK_START (VBLANK_START),
		.VBLANK_END   (VBLANK_END)
	)
	u_blank_timer
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix)
	);

	// Speech boost follows the Sinistar profile
	audio_mixer
	#(
		.LPF_SHIFT (LPF_SHIFT)
	)
	u_audio_mixer
	(
		.clk_sys    (clk_sys),
		.reset      (reset),
		.main_audio (main_audio),
		.speech     (speech),
		.sinistar   (sinistar),
		.audio_out  (audio_out)
	);

endmodule

//--- source/arcade_pkg.sv
/*
 * Arcade I/O shared definitions
 * Vector types, game codes, download indices and joystick bit positions
 */
package arcade_pkg;

	//////////////////////////////////////////////////
	// Player inputs
	//////////////////////////////////////////////////

	// Digital joystick word as delivered by the host
	typedef logic [15:0] joy_word_t;

	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_FIRE_A  = 4;
	localparam int JOY_FIRE_B  = 5;
	localparam int JOY_FIRE_C  = 6;
	localparam int JOY_FIRE_D  = 7;
	localparam int JOY_START1  = 10;
	localparam int JOY_START2  = 11;
	localparam int JOY_COIN    = 12;
	localparam int JOY_ADVANCE = 13;
	localparam int JOY_AUTOUP  = 14;

	// Analog stick, X in the low byte and Y in the high byte
	typedef logic signed [7:0] stick_axis_t;
	typedef logic [15:0]       stick_word_t;

	// Sinistar stick position code
	typedef logic [3:0] stick_pos_t;
	localparam stick_pos_t STICK_CENTER = 4'd7;

	//////////////////////////////////////////////////
	// Board and download
	//////////////////////////////////////////////////

	typedef logic [7:0] io_byte_t;
	typedef logic [7:0] game_id_t;

	localparam game_id_t GAME_ROBOTRON = 8'd0;
	localparam game_id_t GAME_JOUST    = 8'd1;
	localparam game_id_t GAME_BUBBLES  = 8'd3;
	localparam game_id_t GAME_SINISTAR = 8'd6;
	localparam game_id_t GAME_PLAYBALL = 8'd7;

	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t;

	localparam dl_index_t GAME_INDEX = 8'd1;
	localparam dl_index_t DIP_INDEX  = 8'd254;

	//////////////////////////////////////////////////
	// Audio and video
	//////////////////////////////////////////////////

	typedef logic [15:0] audio_sample_t;
	localparam int LPF_SHIFT = 9;

	// Blanking points, horizontal in half-pixel counts
	localparam int HBLANK_START = 336;
	localparam int HBLANK_END   = 40;
	localparam int VBLANK_START = 254;
	localparam int VBLANK_END   = 14;

	typedef logic [10:0] count_t;

endpackage

//--- source/audio_mixer.sv
/*
 * Audio mixer
 * Mixes main sound with speech, boosts Sinistar speech with saturation
 * and smooths the result with a one-pole low-pass filter
 */
`timescale 1ns/1ns

module audio_mixer
#(
	parameter int LPF_SHIFT = arcade_pkg::LPF_SHIFT
)
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  arcade_pkg::io_byte_t      main_audio,
	input  arcade_pkg::audio_sample_t speech,
	input  logic                      sinistar,
	output arcade_pkg::audio_sample_t audio_out
);
	import arcade_pkg::*;

	localparam int ACC_W = 17 + LPF_SHIFT;

	logic signed [15:0] speech_c;
	logic signed [17:0] speech_x4;
	logic signed [15:0] speech_sat;
	audio_sample_t      speech_boost;
	audio_sample_t      speech_sel;
	logic [16:0]        mix;
	logic [ACC_W-1:0]   acc;
	logic [16:0]        filtered;

	//////////////////////////////////////////////////
	// Speech boost
	//////////////////////////////////////////////////

	// Offset binary to two's complement
	assign speech_c  = speech - 16'h8000;
	assign speech_x4 = {speech_c, 2'b00};

	always_comb
	begin
		if (speech_x4 > 18'sd32767)
			speech_sat = 16'sh7fff;
		else if (speech_x4 < -18'sd32768)
			speech_sat = 16'sh8000;
		else
			speech_sat = speech_x4[15:0];
	end

	assign speech_boost = speech_sat + 16'h8000;
	assign speech_sel   = sinistar ? speech_boost : speech;

	//////////////////////////////////////////////////
	// Mix and low-pass
	//////////////////////////////////////////////////

	assign mix = {1'b0, main_audio, 8'h00} + {1'b0, speech_sel};

	// Leaky integrator whose top bits are the filtered sample
	assign filtered = acc[ACC_W-1:LPF_SHIFT];

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			acc <= '0;
		else
			acc <= acc + {{LPF_SHIFT{1'b0}}, mix} - {{LPF_SHIFT{1'b0}}, filtered};
	end

	assign audio_out = {2'b00, filtered[16:3]};

endmodule

//--- source/blank_timer.sv
/*
 * Blanking timer
 * Rebuilds blanking and the pixel enable from the SoC sync pulses
 */
`timescale 1ns/1ns

module blank_timer
#(
	parameter int HBLANK_START = arcade_pkg::HBLANK_START,
	parameter int HBLANK_END   = arcade_pkg::HBLANK_END,
	parameter int VBLANK_START = arcade_pkg::VBLANK_START,
	parameter int VBLANK_END   = arcade_pkg::VBLANK_END
)
(
	input  logic clk_sys,
	input  logic reset,
	input  logic hs,
	input  logic vs,
	output logic hblank,
	output logic vblank,
	output logic ce_pix
);
	import arcade_pkg::*;

	logic   hs_d;
	logic   hs_dd;
	logic   vs_d;
	logic   vs_line;
	logic   hs_rise;
	count_t pcnt;
	count_t lcnt;

	// One register stage on the syncs before edge detection
	assign hs_rise = hs_d & ~hs_dd;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			hs_d    <= 1'b0;
			hs_dd   <= 1'b0;
			vs_d    <= 1'b0;
			vs_line <= 1'b0;
			pcnt    <= '0;
			lcnt    <= '0;
			hblank  <= 1'b0;
			vblank  <= 1'b0;
		end
		else
		begin
			hs_d  <= hs;
			hs_dd <= hs_d;
			vs_d  <= vs;

			// Pixel counter stops at full scale
			if (~&pcnt)
				pcnt <= pcnt + 1'b1;

			if (hs_rise)
			begin
				pcnt <= '0;
				if (~&lcnt)
					lcnt <= lcnt + 1'b1;

				// vs is only looked at once per line
				vs_line <= vs_d;
				if (vs_d & ~vs_line)
					lcnt <= '0;
			end

			if (pcnt[10:1] == HBLANK_START)
				hblank <= 1'b1;
			if (pcnt[10:1] == HBLANK_END)
				hblank <= 1'b0;

			if (lcnt == VBLANK_START)
				vblank <= 1'b1;
			if (lcnt == VBLANK_END)
				vblank <= 1'b0;
		end
	end

	assign ce_pix = pcnt[0];

endmodule

//--- source/control_mapper.sv
/*
 * Control mapper
 * Maps the player joysticks onto each game's input board bytes
 * and flags the game profile
 */
`timescale 1ns/1ns

module control_mapper
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  arcade_pkg::game_id_t    game,
	input  arcade_pkg::io_byte_t    dip0,
	input  logic [1:0]              control_mode,
	input  arcade_pkg::joy_word_t   joy1,
	input  arcade_pkg::joy_word_t   joy2,
	input  arcade_pkg::stick_word_t stick1,
	input  arcade_pkg::stick_word_t stick2,
	output arcade_pkg::io_byte_t    ja,
	output arcade_pkg::io_byte_t    jb,
	output arcade_pkg::io_byte_t    sw,
	output logic [2:0]              btn,
	output logic                    sin_fire,
	output logic                    sin_bomb,
	output logic                    sinistar,
	output logic                    landscape
);
	import arcade_pkg::*;

	joy_word_t  joy_any;
	stick_pos_t pos_x;
	stick_pos_t pos_y;
	logic [3:0] robo_lo;
	logic [3:0] robo_hi;
	io_byte_t   ja_raw;
	io_byte_t   jb_raw;

	// Directions packed as {right, left, down, up}
	function automatic logic [3:0] dirs(input joy_word_t j);
		return {j[JOY_RIGHT], j[JOY_LEFT], j[JOY_DOWN], j[JOY_UP]};
	endfunction

	stick_quantizer u_stick
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.joy1    (joy1),
		.joy2    (joy2),
		.stick1  (stick1),
		.stick2  (stick2),
		.pos_x   (pos_x),
		.pos_y   (pos_y)
	);

	assign joy_any = joy1 | joy2;

	//////////////////////////////////////////////////
	// Robotron twin stick modes
	//////////////////////////////////////////////////

	// Bit 1 splits the players and bit 0 puts the fire stick on the directions
	assign robo_lo = control_mode[1] ? dirs(joy1) : dirs(joy_any);
	assign robo_hi = control_mode[1] ? dirs(joy2) :
	                 control_mode[0] ? dirs(joy_any) :
	                 {joy_any[JOY_FIRE_A], joy_any[JOY_FIRE_D],
	                  joy_any[JOY_FIRE_B], joy_any[JOY_FIRE_C]};

	//////////////////////////////////////////////////
	// Per-game mapping
	//////////////////////////////////////////////////

	always_comb
	begin
		ja_raw    = '0;
		jb_raw    = '0;
		btn       = '0;
		sinistar  = 1'b0;
		landscape = 1'b1;

		case (game)
			GAME_ROBOTRON:
			begin
				btn    = {joy_any[JOY_START1], joy_any[JOY_START2], joy_any[JOY_COIN]};
				ja_raw = {robo_hi, robo_lo};
				jb_raw = ja_raw;
			end
			GAME_JOUST:
			begin
				btn    = {joy_any[JOY_START2], joy_any[JOY_START1], joy_any[JOY_COIN]};
				ja_raw = {5'b00000, joy1[JOY_FIRE_A], joy1[JOY_RIGHT], joy1[JOY_LEFT]};
				jb_raw = {5'b00000, joy2[JOY_FIRE_A], joy2[JOY_RIGHT], joy2[JOY_LEFT]};
			end
			GAME_BUBBLES:
			begin
				btn    = {joy_any[JOY_START2], joy_any[JOY_START1], joy_any[JOY_COIN]};
				ja_raw = {4'b0000, dirs(joy_any)};
				jb_raw = ja_raw;
			end
			GAME_SINISTAR:
			begin
				sinistar  = 1'b1;
				landscape = 1'b0;
				btn       = {joy_any[JOY_START1], joy_any[JOY_START2], joy_any[JOY_COIN]};
				ja_raw    = {pos_x, pos_y};
				jb_raw    = ja_raw;
			end
			GAME_PLAYBALL:
			begin
				landscape = 1'b0;
				btn       = {2'b00, joy_any[JOY_COIN]};
				ja_raw    = {4'b0000, joy_any[JOY_START2], joy_any[JOY_RIGHT],
				             joy_any[JOY_LEFT], joy_any[JOY_START1]};
				jb_raw    = ja_raw;
			end
			default:
			begin
				// Unknown board keeps every line released
			end
		endcase
	end

	// Input board lines are active low
	assign ja = ~ja_raw;
	assign jb = ~jb_raw;

	assign sw = dip0 | {6'b000000, joy_any[JOY_ADVANCE], joy_any[JOY_AUTOUP]};

	// Sinistar fire and bomb buttons
	assign sin_fire = ~joy_any[JOY_FIRE_A];
	assign sin_bomb = ~joy_any[JOY_FIRE_B];

endmodule

//--- source/game_select.sv
/*
 * Game select
 * Decodes download writes into the game code and DIP byte 0
 */
`timescale 1ns/1ns

module game_select
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_wr,
	input  arcade_pkg::dl_index_t dl_index,
	input  arcade_pkg::dl_addr_t  dl_addr,
	input  arcade_pkg::io_byte_t  dl_data,
	output arcade_pkg::game_id_t  game,
	output arcade_pkg::io_byte_t  dip0
);
	import arcade_pkg::*;

	logic game_wr;
	logic dip_wr;

	// Any address under the game index carries the code
	assign game_wr = dl_wr && (dl_index == GAME_INDEX);

	// Only the first DIP byte is kept
	assign dip_wr = dl_wr && (dl_index == DIP_INDEX) && (dl_addr == '0);

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			game <= GAME_ROBOTRON;
			dip0 <= '0;
		end
		else
		begin
			if (game_wr)
				game <= dl_data;
			if (dip_wr)
				dip0 <= dl_data;
		end
	end

endmodule

//--- source/stick_quantizer.sv
/*
 * Stick quantizer
 * Picks the stick of the last active player and turns it into
 * Sinistar position codes, falling back to the digital directions
 */
`timescale 1ns/1ns

module stick_quantizer
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  arcade_pkg::joy_word_t   joy1,
	input  arcade_pkg::joy_word_t   joy2,
	input  arcade_pkg::stick_word_t stick1,
	input  arcade_pkg::stick_word_t stick2,
	output arcade_pkg::stick_pos_t  pos_x,
	output arcade_pkg::stick_pos_t  pos_y
);
	import arcade_pkg::*;

	logic        j2;
	joy_word_t   joy_any;
	stick_word_t stick_sel;
	stick_axis_t axis_x;
	stick_axis_t axis_y;
	stick_pos_t  ana_x;
	stick_pos_t  ana_y;
	stick_pos_t  dig_x;
	stick_pos_t  dig_y;

	// Y runs the other way round on the cabinet stick
	function automatic stick_pos_t quantize(input stick_axis_t v, input logic mirror);
		stick_pos_t p;
		if (v < -96)
			p = mirror ? 4'd8 : 4'd0;
		else if (v < -64)
			p = mirror ? 4'd9 : 4'd4;
		else if (v < -32)
			p = mirror ? 4'd11 : 4'd6;
		else if (v > 96)
			p = mirror ? 4'd0 : 4'd8;
		else if (v > 64)
			p = mirror ? 4'd4 : 4'd9;
		else if (v > 32)
			p = mirror ? 4'd6 : 4'd11;
		else
			p = STICK_CENTER;
		return p;
	endfunction

	// Player 1 activity wins over player 2
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			j2 <= 1'b0;
		else if (joy1 != '0)
			j2 <= 1'b0;
		else if (joy2 != '0)
			j2 <= 1'b1;
	end

	assign joy_any   = joy1 | joy2;
	assign stick_sel = j2 ? stick2 : stick1;
	assign axis_x    = stick_sel[7:0];
	assign axis_y    = stick_sel[15:8];

	assign ana_x = quantize(axis_x, 1'b0);
	assign ana_y = quantize(axis_y, 1'b1);

	assign dig_x = joy_any[JOY_LEFT] ? 4'd0 : (joy_any[JOY_RIGHT] ? 4'd8 : STICK_CENTER);
	assign dig_y = joy_any[JOY_DOWN] ? 4'd0 : (joy_any[JOY_UP] ? 4'd8 : STICK_CENTER);

	// Centered stick hands over to the digital pad
	assign pos_x = (ana_x == STICK_CENTER) ? dig_x : ana_x;
	assign pos_y = (ana_y == STICK_CENTER) ? dig_y : ana_y;

endmodule
